// File: design/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data and address word width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_NREG 32

// memory depths, in words
`define MIPS_IMEM_WORDS 256
`define MIPS_DMEM_WORDS 256

`endif

// File: design/mips_isa_pkg.sv
package mips_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        F_SLL = 6'h00,
        F_SRL = 6'h02,
        F_SRA = 6'h03,
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_XOR = 6'h26,
        F_SLT = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     op;
        logic [25:0] target;
    } j_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

// File: design/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

    // ALU function select
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8,
        ALU_LUI = 4'd9
    } alu_op_e;

    // next-PC choice, bit 0 branch and bit 1 jump
    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2
    } pc_src_e;

    // source of the register writeback value
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_RA  = 2'd2  // return address for jal
    } wb_src_e;

endpackage

// File: design/decode_if.sv
`timescale 1ns/1ps

interface decode_if;

    logic                  wreg;    // register write enable
    logic                  regrt;   // destination is rt, not rd
    logic                  aluimm;  // operand b from immediate
    logic                  sext;    // sign-extend the immediate
    logic                  shift;   // operand a from shamt
    logic                  wmem;    // store enable
    mips_ctrl_pkg::alu_op_e alu_op;
    mips_ctrl_pkg::wb_src_e wb_src;
    mips_ctrl_pkg::pc_src_e pc_src;

    modport decoder (
        output wreg, regrt, aluimm, sext, shift, wmem, alu_op, wb_src, pc_src
    );

    modport fetch (
        input pc_src
    );

    modport exec (
        input wreg, regrt, aluimm, sext, shift, wmem, alu_op, wb_src
    );

endinterface

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  mips_isa_pkg::opcode_e op,
    input  mips_isa_pkg::funct_e  funct,
    input  logic                  zero,
    decode_if.decoder             ctrl
);

    logic is_beq;
    logic is_bne;
    logic is_jump;

    always_comb begin
        ctrl.wreg   = 1'b0;
        ctrl.regrt  = 1'b0;
        ctrl.aluimm = 1'b0;
        ctrl.sext   = 1'b1;
        ctrl.shift  = 1'b0;
        ctrl.wmem   = 1'b0;
        ctrl.alu_op = mips_ctrl_pkg::ALU_ADD;
        ctrl.wb_src = mips_ctrl_pkg::WB_ALU;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        is_jump     = 1'b0;
        case (op)
            mips_isa_pkg::OP_RTYPE: begin
                ctrl.wreg = 1'b1;
                case (funct)
                    mips_isa_pkg::F_ADD: ctrl.alu_op = mips_ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUB: ctrl.alu_op = mips_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND: ctrl.alu_op = mips_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:  ctrl.alu_op = mips_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::F_XOR: ctrl.alu_op = mips_ctrl_pkg::ALU_XOR;
                    mips_isa_pkg::F_SLT: ctrl.alu_op = mips_ctrl_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLL: begin
                        ctrl.alu_op = mips_ctrl_pkg::ALU_SLL;
                        ctrl.shift  = 1'b1;
                    end
                    mips_isa_pkg::F_SRL: begin
                        ctrl.alu_op = mips_ctrl_pkg::ALU_SRL;
                        ctrl.shift  = 1'b1;
                    end
                    mips_isa_pkg::F_SRA: begin
                        ctrl.alu_op = mips_ctrl_pkg::ALU_SRA;
                        ctrl.shift  = 1'b1;
                    end
                    default: ctrl.wreg = 1'b0;  // unknown funct is a no-op
                endcase
            end
            mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_LW: begin
                ctrl.wreg   = 1'b1;
                ctrl.regrt  = 1'b1;
                ctrl.aluimm = 1'b1;
                if (op == mips_isa_pkg::OP_LW) ctrl.wb_src = mips_ctrl_pkg::WB_MEM;
            end
            mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
            mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI: begin
                ctrl.wreg   = 1'b1;
                ctrl.regrt  = 1'b1;
                ctrl.aluimm = 1'b1;
                ctrl.sext   = 1'b0;  // logical immediates zero-extend
                case (op)
                    mips_isa_pkg::OP_ANDI: ctrl.alu_op = mips_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::OP_ORI:  ctrl.alu_op = mips_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::OP_XORI: ctrl.alu_op = mips_ctrl_pkg::ALU_XOR;
                    default:               ctrl.alu_op = mips_ctrl_pkg::ALU_LUI;
                endcase
            end
            mips_isa_pkg::OP_SW: begin
                ctrl.aluimm = 1'b1;
                ctrl.wmem   = 1'b1;
            end
            mips_isa_pkg::OP_BEQ: begin
                ctrl.alu_op = mips_ctrl_pkg::ALU_SUB;  // zero flag compares rs and rt
                is_beq      = 1'b1;
            end
            mips_isa_pkg::OP_BNE: begin
                ctrl.alu_op = mips_ctrl_pkg::ALU_SUB;
                is_bne      = 1'b1;
            end
            mips_isa_pkg::OP_J: is_jump = 1'b1;
            mips_isa_pkg::OP_JAL: begin
                is_jump     = 1'b1;
                ctrl.wreg   = 1'b1;
                ctrl.wb_src = mips_ctrl_pkg::WB_RA;
            end
            default: ;  // unsupported opcode, no writes
        endcase
    end

    // kept apart from the decode so zero only feeds pc_src
    always_comb begin
        if (is_jump)
            ctrl.pc_src = mips_ctrl_pkg::PC_JUMP;
        else if ((is_beq && zero) || (is_bne && !zero))
            ctrl.pc_src = mips_ctrl_pkg::PC_BRANCH;
        else
            ctrl.pc_src = mips_ctrl_pkg::PC_SEQ;
    end

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetch_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic                                imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
    input  logic [`MIPS_XLEN-1:0]               imem_wdata,
    decode_if.fetch                             ctrl,
    output logic [`MIPS_XLEN-1:0]               pc,
    output mips_isa_pkg::instr_u                instr,
    output logic [`MIPS_XLEN-1:0]               pc_plus4
);

    localparam int IA = $clog2(`MIPS_IMEM_WORDS);

    logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_WORDS];
    logic [`MIPS_XLEN-1:0] pc_next;
    logic [`MIPS_XLEN-1:0] br_offset;
    logic [`MIPS_XLEN-1:0] br_target;
    logic [`MIPS_XLEN-1:0] jmp_target;

    // program load, only while the core is halted
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign instr    = imem[pc[IA+1:2]];  // word addressed
    assign pc_plus4 = pc + `MIPS_XLEN'd4;

    assign br_offset  = {{(`MIPS_XLEN-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign br_target  = pc_plus4 + br_offset;
    assign jmp_target = {pc_plus4[`MIPS_XLEN-1:28], instr.j.target, 2'b00};

    always_comb begin
        case (ctrl.pc_src)
            mips_ctrl_pkg::PC_BRANCH: pc_next = br_target;
            mips_ctrl_pkg::PC_JUMP:   pc_next = jmp_target;
            default:                  pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;  // one retire per cycle
        end
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  logic [4:0]            raddr_a,
    input  logic [4:0]            raddr_b,
    input  logic [4:0]            waddr,
    input  logic [`MIPS_XLEN-1:0] wdata,
    output logic [`MIPS_XLEN-1:0] rdata_a,
    output logic [`MIPS_XLEN-1:0] rdata_b
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREG];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `MIPS_NREG; k++) begin
                regs[k] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;  // r0 writes dropped
        end
    end

    // asynchronous reads, r0 hardwired
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module execute_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    decode_if.exec                ctrl,
    input  mips_isa_pkg::instr_u  instr,
    input  logic [`MIPS_XLEN-1:0] pc_plus4,
    input  logic [`MIPS_XLEN-1:0] rs_val,
    input  logic [`MIPS_XLEN-1:0] rt_val,
    output logic                  zero,
    output logic                  wb_we,
    output logic                  dmem_we,
    output logic [4:0]            wb_addr,
    output logic [`MIPS_XLEN-1:0] wb_data,
    output logic [`MIPS_XLEN-1:0] dmem_addr,
    output logic [`MIPS_XLEN-1:0] dmem_wdata
);

    localparam int DA = $clog2(`MIPS_DMEM_WORDS);

    logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_WORDS];
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] alu_res;
    logic [DA-1:0]         dmem_idx;
    logic [4:0]            shamt;

    assign imm_ext = ctrl.sext ? {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm}
                               : {{(`MIPS_XLEN-16){1'b0}}, instr.i.imm};

    assign op_a  = ctrl.shift ? {{(`MIPS_XLEN-5){1'b0}}, instr.r.shamt} : rs_val;
    assign op_b  = ctrl.aluimm ? imm_ext : rt_val;
    assign shamt = op_a[4:0];

    always_comb begin
        case (ctrl.alu_op)
            mips_ctrl_pkg::ALU_SUB: alu_res = op_a - op_b;
            mips_ctrl_pkg::ALU_AND: alu_res = op_a & op_b;
            mips_ctrl_pkg::ALU_OR:  alu_res = op_a | op_b;
            mips_ctrl_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            mips_ctrl_pkg::ALU_SLT: begin
                alu_res = {{(`MIPS_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            mips_ctrl_pkg::ALU_SLL: alu_res = op_b << shamt;
            mips_ctrl_pkg::ALU_SRL: alu_res = op_b >> shamt;
            mips_ctrl_pkg::ALU_SRA: alu_res = $signed(op_b) >>> shamt;  // sign fill
            mips_ctrl_pkg::ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
            default:                alu_res = op_a + op_b;
        endcase
    end

    assign zero = (alu_res == '0);  // branch compare

    // word-addressed data memory
    assign dmem_idx   = alu_res[DA+1:2];
    assign dmem_addr  = alu_res;
    assign dmem_wdata = rt_val;
    assign dmem_we    = run & ctrl.wmem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `MIPS_DMEM_WORDS; k++) begin
                dmem[k] <= '0;
            end
        end else if (dmem_we) begin
            dmem[dmem_idx] <= rt_val;
        end
    end

    // writeback selection, jal forced to r31
    assign wb_we = run & ctrl.wreg;

    always_comb begin
        if (ctrl.wb_src == mips_ctrl_pkg::WB_RA)
            wb_addr = 5'd31;
        else if (ctrl.regrt)
            wb_addr = instr.r.rt;
        else
            wb_addr = instr.r.rd;
    end

    always_comb begin
        case (ctrl.wb_src)
            mips_ctrl_pkg::WB_MEM: wb_data = dmem[dmem_idx];
            mips_ctrl_pkg::WB_RA:  wb_data = pc_plus4;
            default:               wb_data = alu_res;
        endcase
    end

endmodule

// File: design/mips_core.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic                                imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
    input  logic [`MIPS_XLEN-1:0]               imem_wdata,
    output logic [`MIPS_XLEN-1:0]               pc,
    output logic                                retire,
    output logic                                wb_we,
    output logic [4:0]                          wb_addr,
    output logic [`MIPS_XLEN-1:0]               wb_data,
    output logic                                dmem_we,
    output logic [`MIPS_XLEN-1:0]               dmem_addr,
    output logic [`MIPS_XLEN-1:0]               dmem_wdata
);

    decode_if dec ();

    mips_isa_pkg::instr_u  instr;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic                  zero;

    assign retire = run;  // single cycle, one retire per run cycle

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .ctrl       (dec),
        .pc         (pc),
        .instr      (instr),
        .pc_plus4   (pc_plus4)
    );

    control_unit u_ctrl (
        .op    (instr.r.op),
        .funct (instr.r.funct),
        .zero  (zero),
        .ctrl  (dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (wb_we),
        .raddr_a (instr.r.rs),
        .raddr_b (instr.r.rt),
        .waddr   (wb_addr),
        .wdata   (wb_data),
        .rdata_a (rs_val),
        .rdata_b (rt_val)
    );

    execute_unit u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .ctrl       (dec),
        .instr      (instr),
        .pc_plus4   (pc_plus4),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .zero       (zero),
        .wb_we      (wb_we),
        .dmem_we    (dmem_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

endmodule

// File: dv/mips_core_properties.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module mips_core_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  run,
    input logic                  retire,
    input logic                  wb_we,
    input logic                  dmem_we,
    input logic [`MIPS_XLEN-1:0] pc
);

    // halted core retires nothing and writes nothing
    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !retire && !wb_we && !dmem_we)
        else $error("retire or write strobe high with run low");

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !run |=> $stable(pc))
        else $error("pc moved while run was low");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    // first edge after reset release
    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> !wb_we && !dmem_we)
        else $error("write strobe high right out of reset");

endmodule

bind mips_core mips_core_properties u_props (.*);

// File: dv/tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_core;

    localparam int IA          = $clog2(`MIPS_IMEM_WORDS);
    localparam int DA          = $clog2(`MIPS_DMEM_WORDS);
    localparam int RUN_TIMEOUT = 2000;  // cycles per program
    localparam int N_PROGRAMS  = 8;

    logic                  clk;
    logic                  rst_n;
    logic                  run;
    logic                  imem_we;
    logic [IA-1:0]         imem_addr;
    logic [`MIPS_XLEN-1:0] imem_wdata;
    logic [`MIPS_XLEN-1:0] pc;
    logic                  retire;
    logic                  wb_we;
    logic [4:0]            wb_addr;
    logic [`MIPS_XLEN-1:0] wb_data;
    logic                  dmem_we;
    logic [`MIPS_XLEN-1:0] dmem_addr;
    logic [`MIPS_XLEN-1:0] dmem_wdata;

    int seed = 46;
    int errors;
    int checks;
    bit timed_out;

    mips_isa_pkg::instr_u  prog [`MIPS_IMEM_WORDS];
    int                    prog_len;

    // instruction-set model state
    logic [`MIPS_XLEN-1:0] m_regs [`MIPS_NREG];
    logic [`MIPS_XLEN-1:0] m_dmem [`MIPS_DMEM_WORDS];
    logic [`MIPS_XLEN-1:0] m_pc;

    // expected effects of the instruction at m_pc
    logic [`MIPS_XLEN-1:0] exp_next_pc;
    logic                  exp_wb_we;
    logic [4:0]            exp_wb_addr;
    logic [`MIPS_XLEN-1:0] exp_wb_data;
    logic                  exp_dmem_we;
    logic [`MIPS_XLEN-1:0] exp_dmem_addr;
    logic [`MIPS_XLEN-1:0] exp_dmem_wdata;

    mips_core u_mips_core (.*);

    always #2 clk = ~clk;

    function automatic int rand_below(input int m);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % m;
    endfunction

    task automatic check_value(input string name, input logic [`MIPS_XLEN-1:0] exp_v,
                               input logic [`MIPS_XLEN-1:0] got);
        checks++;
        assert (got === exp_v) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp_v, got);
            errors++;
        end
    endtask

    // forward-only control flow, last word jumps to itself
    task automatic gen_program;
        mips_isa_pkg::instr_u w;
        int kind;
        int room;
        prog_len = 20 + rand_below(16);
        for (int i = 0; i < prog_len - 1; i++) begin
            w = '0;
            w.r.rs = 5'(rand_below(8));
            w.r.rt = 5'(rand_below(8));
            w.r.rd = 5'(rand_below(8));  // r0 included on purpose
            kind = rand_below(15);
            room = prog_len - 2 - i;  // words left before the final loop
            case (kind)
                0, 1, 2, 3: begin
                    case (rand_below(6))
                        0: w.r.funct = mips_isa_pkg::F_ADD;
                        1: w.r.funct = mips_isa_pkg::F_SUB;
                        2: w.r.funct = mips_isa_pkg::F_AND;
                        3: w.r.funct = mips_isa_pkg::F_OR;
                        4: w.r.funct = mips_isa_pkg::F_XOR;
                        default: w.r.funct = mips_isa_pkg::F_SLT;
                    endcase
                end
                4, 5: begin
                    w.r.rs    = 5'd0;
                    w.r.shamt = 5'(rand_below(32));
                    case (rand_below(3))
                        0: w.r.funct = mips_isa_pkg::F_SLL;
                        1: w.r.funct = mips_isa_pkg::F_SRL;
                        default: w.r.funct = mips_isa_pkg::F_SRA;
                    endcase
                end
                6, 7, 8: begin
                    w.i.imm = 16'($random(seed));
                    case (rand_below(5))
                        0: w.i.op = mips_isa_pkg::OP_ADDI;
                        1: w.i.op = mips_isa_pkg::OP_ANDI;
                        2: w.i.op = mips_isa_pkg::OP_ORI;
                        3: w.i.op = mips_isa_pkg::OP_XORI;
                        default: w.i.op = mips_isa_pkg::OP_LUI;
                    endcase
                end
                9, 10: begin
                    w.i.op  = (kind == 9) ? mips_isa_pkg::OP_LW : mips_isa_pkg::OP_SW;
                    w.i.rs  = 5'd0;
                    w.i.imm = 16'(4 * rand_below(16));  // lower data words
                end
                11, 12: begin
                    w.i.op = (kind == 11) ? mips_isa_pkg::OP_BEQ : mips_isa_pkg::OP_BNE;
                    if (rand_below(2) == 0) w.i.rt = w.i.rs;
                    w.i.imm = 16'(rand_below((room < 3) ? room + 1 : 4));
                end
                default: begin
                    w.j.op     = (kind == 13) ? mips_isa_pkg::OP_J : mips_isa_pkg::OP_JAL;
                    w.j.target = 26'(i + 1 + rand_below((room < 3) ? room + 1 : 4));
                end
            endcase
            prog[i] = w;
        end
        w          = '0;
        w.j.op     = mips_isa_pkg::OP_J;
        w.j.target = 26'(prog_len - 1);
        prog[prog_len-1] = w;
    endtask

    task automatic predict;
        mips_isa_pkg::instr_u  w;
        logic [`MIPS_XLEN-1:0] rs_v;
        logic [`MIPS_XLEN-1:0] rt_v;
        logic [`MIPS_XLEN-1:0] simm;
        logic [`MIPS_XLEN-1:0] zimm;
        logic [`MIPS_XLEN-1:0] pc4;
        w    = prog[m_pc[IA+1:2]];
        rs_v = m_regs[w.r.rs];
        rt_v = m_regs[w.r.rt];
        simm = {{16{w.i.imm[15]}}, w.i.imm};
        zimm = {16'h0000, w.i.imm};
        pc4  = m_pc + 32'd4;
        exp_next_pc    = pc4;
        exp_wb_we      = 1'b1;
        exp_wb_addr    = w.i.rt;
        exp_wb_data    = '0;
        exp_dmem_we    = 1'b0;
        exp_dmem_addr  = rs_v + simm;
        exp_dmem_wdata = rt_v;
        case (w.r.op)
            mips_isa_pkg::OP_RTYPE: begin
                exp_wb_addr = w.r.rd;
                case (w.r.funct)
                    mips_isa_pkg::F_ADD: exp_wb_data = rs_v + rt_v;
                    mips_isa_pkg::F_SUB: exp_wb_data = rs_v - rt_v;
                    mips_isa_pkg::F_AND: exp_wb_data = rs_v & rt_v;
                    mips_isa_pkg::F_OR:  exp_wb_data = rs_v | rt_v;
                    mips_isa_pkg::F_XOR: exp_wb_data = rs_v ^ rt_v;
                    mips_isa_pkg::F_SLT: exp_wb_data = ($signed(rs_v) < $signed(rt_v)) ? 1 : 0;
                    mips_isa_pkg::F_SLL: exp_wb_data = rt_v << w.r.shamt;
                    mips_isa_pkg::F_SRL: exp_wb_data = rt_v >> w.r.shamt;
                    mips_isa_pkg::F_SRA: exp_wb_data = $signed(rt_v) >>> w.r.shamt;
                    default:             exp_wb_we   = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDI: exp_wb_data = rs_v + simm;
            mips_isa_pkg::OP_ANDI: exp_wb_data = rs_v & zimm;
            mips_isa_pkg::OP_ORI:  exp_wb_data = rs_v | zimm;
            mips_isa_pkg::OP_XORI: exp_wb_data = rs_v ^ zimm;
            mips_isa_pkg::OP_LUI:  exp_wb_data = {w.i.imm, 16'h0000};
            mips_isa_pkg::OP_LW:   exp_wb_data = m_dmem[exp_dmem_addr[DA+1:2]];
            mips_isa_pkg::OP_SW: begin
                exp_wb_we   = 1'b0;
                exp_dmem_we = 1'b1;
            end
            mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
                exp_wb_we = 1'b0;
                if ((rs_v == rt_v) == (w.i.op == mips_isa_pkg::OP_BEQ))
                    exp_next_pc = pc4 + (simm << 2);
            end
            default: begin  // j and jal
                exp_next_pc = {pc4[31:28], w.j.target, 2'b00};
                exp_wb_we   = (w.j.op == mips_isa_pkg::OP_JAL);
                exp_wb_addr = 5'd31;
                exp_wb_data = pc4;
            end
        endcase
    endtask

    task automatic commit;
        if (exp_wb_we && exp_wb_addr != 5'd0) m_regs[exp_wb_addr] = exp_wb_data;
        if (exp_dmem_we) m_dmem[exp_dmem_addr[DA+1:2]] = exp_dmem_wdata;
        m_pc = exp_next_pc;
    endtask

    task automatic check_retire;
        check_value("retire", 1, retire);
        check_value("pc", m_pc, pc);
        check_value("wb_we", exp_wb_we, wb_we);
        if (exp_wb_we) begin
            check_value("wb_addr", exp_wb_addr, wb_addr);
            check_value("wb_data", exp_wb_data, wb_data);
        end
        check_value("dmem_we", exp_dmem_we, dmem_we);
        if (exp_dmem_we) begin
            check_value("dmem_addr", exp_dmem_addr, dmem_addr);
            check_value("dmem_wdata", exp_dmem_wdata, dmem_wdata);
        end
    endtask

    task automatic load_program;
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = IA'(i);
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic apply_reset;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < `MIPS_NREG; k++) m_regs[k] = '0;
        for (int k = 0; k < `MIPS_DMEM_WORDS; k++) m_dmem[k] = '0;
        m_pc = '0;
    endtask

    task automatic run_program;
        int waited;
        int stall_left;
        int halt_seen;
        logic [`MIPS_XLEN-1:0] halt_pc;
        waited     = 0;
        stall_left = 0;
        halt_seen  = 0;
        halt_pc    = 32'(4 * (prog_len - 1));
        while (halt_seen < 2 && waited < RUN_TIMEOUT) begin
            @(negedge clk);
            if (stall_left == 0 && rand_below(6) == 0) stall_left = 1 + rand_below(4);
            run = (stall_left == 0);
            if (stall_left > 0) stall_left--;
            // stray load attempt while running must be ignored
            imem_we    = run && (rand_below(8) == 0);
            imem_addr  = IA'(rand_below(prog_len));
            imem_wdata = $random(seed);
            #1;  // outputs settled, well before the rising edge
            if (run) begin
                if (m_pc == halt_pc) halt_seen++;
                predict();
                check_retire();
                commit();
            end else begin
                check_value("pc", m_pc, pc);
                assert (!retire && !wb_we && !dmem_we) else begin
                    $display("retire or a write strobe is high while run is low");
                    errors++;
                end
            end
            waited++;
        end
        @(negedge clk);
        run     = 1'b0;
        imem_we = 1'b0;
        if (halt_seen < 2) begin
            $display("timeout, the program never reached its final self-loop");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        errors     = 0;
        checks     = 0;
        timed_out  = 1'b0;
        for (int p = 0; p < N_PROGRAMS && !timed_out; p++) begin
            gen_program();
            load_program();  // run is low here
            apply_reset();
            run_program();
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_ctrl_pkg.sv
design/decode_if.sv
design/control_unit.sv
design/fetch_unit.sv
design/reg_file.sv
design/execute_unit.sv
design/mips_core.sv
dv/mips_core_properties.sv
dv/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/mips_isa_pkg.sv
      - design/mips_ctrl_pkg.sv
      - design/decode_if.sv
      - design/control_unit.sv
      - design/fetch_unit.sv
      - design/reg_file.sv
      - design/execute_unit.sv
      - design/mips_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/mips_core_properties.sv
      - dv/tb_mips_core.sv
